//--- tb.f
rtl/cdr_pkg.sv
rtl/alexander_pd.sv
rtl/cdr_loop_filter.sv
rtl/cdr_cfg_regs.sv
rtl/cdr_core.sv
sim/cdr_sva.sv
sim/cdr_tb.sv

//--- Bender.yml
package:
  name: cdr_backend

sources:
  # design
  - files:
      - rtl/cdr_pkg.sv
      - rtl/alexander_pd.sv
      - rtl/cdr_loop_filter.sv
      - rtl/cdr_cfg_regs.sv
      - rtl/cdr_core.sv

  # verification
  - target: simulation
    files:
      - sim/cdr_sva.sv
      - sim/cdr_tb.sv

//--- sim/cdr_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for cdr_core with a reference model compared after every rising edge
module cdr_tb;

  logic                          clk;
  logic                          rst_n;
  logic                          sample_valid;
  logic                          data_smp;
  logic                          edge_smp;
  logic                          cfg_we;
  cdr_pkg::cfg_addr_e            cfg_addr;
  logic [cdr_pkg::CFG_DW-1:0]    cfg_wdata;
  logic [cdr_pkg::CFG_DW-1:0]    cfg_rdata;
  cdr_pkg::pd_dec_t              pd_dec;
  logic [cdr_pkg::CODE_W-1:0]    code;

  cdr_pkg::cfg_addr_e            rd_addr;    // address shown on idle cycles
  logic                          last_data;  // last data bit sent

  // reference model state
  logic                          m_prev;
  logic                          m_primed;
  logic                          m_valid;
  cdr_pkg::pd_dec_e              m_dec;
  int                            m_freq;   // signed 16 bit range
  int                            m_phase;  // 0 .. 2^24-1
  logic [cdr_pkg::PHUG_W-1:0]    m_phug;
  logic [cdr_pkg::FRUG_W-1:0]    m_frug;
  logic                          m_en;
  logic                          m_clr;
  int                            m_cnt;

  cdr_core i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .data_smp     (data_smp),
    .edge_smp     (edge_smp),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .pd_dec       (pd_dec),
    .code         (code)
  );

  always #2 clk = ~clk;  // 4 ns period

  // alexander table from prev / edge / current
  function automatic cdr_pkg::pd_dec_e classify_bit(logic p, logic e, logic c);
    if (p == c) begin
      return (e == c) ? cdr_pkg::PD_NONE : cdr_pkg::PD_INVALID;
    end
    return (e == p) ? cdr_pkg::PD_EARLY : cdr_pkg::PD_LATE;
  endfunction

  function automatic int step_sign(cdr_pkg::pd_dec_e d);
    return (d == cdr_pkg::PD_LATE) ? 1 : -1;  // late pushes the phase forward
  endfunction

  // 16 bit two's complement wrap
  function automatic int next_freq(int fr, int dir, int gain);
    int v;
    v = (fr + dir * gain) & 32'h0000_ffff;
    if (v >= 32768) v = v - 65536;
    return v;
  endfunction

  // old freq slice plus signed gain mod 2^24
  function automatic int next_phase(int ph, int fr, int dir, int gain);
    return (ph + (fr >>> cdr_pkg::FREQ_SHIFT) + dir * gain) & ((1 << cdr_pkg::PHASE_W) - 1);
  endfunction

  function automatic logic [cdr_pkg::CFG_DW-1:0] model_rdata(cdr_pkg::cfg_addr_e a);
    case (a)
      cdr_pkg::REG_PHUG: return cdr_pkg::CFG_DW'(m_phug);
      cdr_pkg::REG_FRUG: return cdr_pkg::CFG_DW'(m_frug);
      cdr_pkg::REG_CTRL: return cdr_pkg::CFG_DW'(m_en);  // clear never reads back
      default:           return cdr_pkg::CFG_DW'(m_cnt);
    endcase
  endfunction

  // model clocked like the dut
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_prev   <= 1'b0;
      m_primed <= 1'b0;
      m_valid  <= 1'b0;
      m_dec    <= cdr_pkg::PD_NONE;
      m_freq   <= 0;
      m_phase  <= 0;
      m_phug   <= 12'd500;
      m_frug   <= 10'd80;
      m_en     <= 1'b1;
      m_clr    <= 1'b0;
      m_cnt    <= 0;
    end else begin
      m_valid <= sample_valid;
      if (sample_valid) begin
        m_prev   <= data_smp;
        m_primed <= 1'b1;
        m_dec    <= m_primed ? classify_bit(m_prev, edge_smp, data_smp) : cdr_pkg::PD_NONE;
      end
      m_clr <= cfg_we && (cfg_addr == cdr_pkg::REG_CTRL) && cfg_wdata[1];
      if (cfg_we && cfg_addr == cdr_pkg::REG_PHUG) m_phug <= cfg_wdata[11:0];
      if (cfg_we && cfg_addr == cdr_pkg::REG_FRUG) m_frug <= cfg_wdata[9:0];
      if (cfg_we && cfg_addr == cdr_pkg::REG_CTRL) m_en <= cfg_wdata[0];
      if (cfg_we && cfg_addr == cdr_pkg::REG_STATUS) begin
        m_cnt <= 0;
      end else if (m_valid && m_dec == cdr_pkg::PD_INVALID && m_cnt < 255) begin
        m_cnt <= m_cnt + 1;  // saturates at 255
      end
      if (m_clr) begin
        m_freq  <= 0;  // clear beats any decision
        m_phase <= 0;
      end else if (m_en && m_valid &&
                   (m_dec == cdr_pkg::PD_LATE || m_dec == cdr_pkg::PD_EARLY)) begin
        m_freq  <= next_freq(m_freq, step_sign(m_dec), int'(m_frug));
        m_phase <= next_phase(m_phase, m_freq, step_sign(m_dec), int'(m_phug));
      end
    end
  end

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
    stop_with_failure();
  endtask

  task automatic check_outputs();
    int exp_code;
    exp_code = m_phase >> (cdr_pkg::PHASE_W - cdr_pkg::CODE_W);  // top bits of phase
    assert (code === exp_code[cdr_pkg::CODE_W-1:0])
      else report_mismatch("code", exp_code, code);
    assert (pd_dec.valid === m_valid)
      else report_mismatch("pd_dec.valid", m_valid, pd_dec.valid);
    if (m_valid) begin
      assert (pd_dec.dec === m_dec) else report_mismatch("pd_dec.dec", m_dec, pd_dec.dec);
    end
    assert (cfg_rdata === model_rdata(cfg_addr))
      else report_mismatch("cfg_rdata", model_rdata(cfg_addr), cfg_rdata);
    // failures raised by the bound protocol checker
    assert (i_dut.u_sva.fail_cnt == 0)
      else begin
        $display("A concurrent protocol assertion on cdr_core failed");
        stop_with_failure();
      end
  endtask

  // outputs settled 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (rst_n) check_outputs();
  end

  // one cycle of inputs applied on the falling edge
  task automatic drive_cycle(input logic sv, input logic d, input logic e, input logic we,
                             input cdr_pkg::cfg_addr_e a, input logic [15:0] wd);
    @(negedge clk);
    sample_valid = sv;
    data_smp     = d;
    edge_smp     = e;
    cfg_we       = we;
    cfg_addr     = a;
    cfg_wdata    = wd;
  endtask

  task automatic send_bit(input logic d, input logic e);
    drive_cycle(1'b1, d, e, 1'b0, rd_addr, 16'h0000);
    last_data = d;
  endtask

  task automatic send_idle();
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, rd_addr, 16'h0000);
  endtask

  task automatic write_reg(input cdr_pkg::cfg_addr_e a, input logic [15:0] wd);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, a, wd);
  endtask

  // pick data and edge that give the wanted decision
  task automatic send_kind(input cdr_pkg::pd_dec_e k);
    case (k)
      cdr_pkg::PD_NONE:  send_bit(last_data, last_data);
      cdr_pkg::PD_EARLY: send_bit(~last_data, last_data);
      cdr_pkg::PD_LATE:  send_bit(~last_data, ~last_data);
      default:           send_bit(last_data, ~last_data);  // invalid
    endcase
  endtask

  task automatic expect_read(input cdr_pkg::cfg_addr_e a, input logic [15:0] value);
    rd_addr = a;
    send_idle();
    @(posedge clk);
    #1;
    assert (cfg_rdata === value) else report_mismatch("cfg_rdata", value, cfg_rdata);
  endtask

  task automatic wait_decision(input int max_cycles);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!pd_dec.valid && n < max_cycles);
    if (!pd_dec.valid) begin
      $display("Timeout: no phase decision within %0d cycles", max_cycles);
      stop_with_failure();
    end
  endtask

  // random pairs with idle gaps
  task automatic random_run(input int n, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      if ($urandom_range(99) < gap_pct) send_idle();
      else send_bit(1'($urandom_range(1)), 1'($urandom_range(1)));
    end
  endtask

  initial begin
    #200_000;
    $display("Timeout: simulation ran past its time limit");
    stop_with_failure();
  end

  initial begin
    int hold_code;
    logic d;
    void'($urandom(49));
    clk = 1'b0;
    rst_n = 1'b0;
    sample_valid = 1'b0;
    data_smp = 1'b0;
    edge_smp = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = cdr_pkg::REG_PHUG;
    cfg_wdata = '0;
    rd_addr = cdr_pkg::REG_STATUS;
    last_data = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // reset state
    @(posedge clk);
    #1;
    assert (code === '0) else report_mismatch("code", 0, code);
    assert (pd_dec.valid === 1'b0) else report_mismatch("pd_dec.valid", 0, pd_dec.valid);
    expect_read(cdr_pkg::REG_PHUG, 16'd500);
    expect_read(cdr_pkg::REG_FRUG, 16'd80);
    expect_read(cdr_pkg::REG_CTRL, 16'd1);
    expect_read(cdr_pkg::REG_STATUS, 16'd0);

    // detector table where the first pair only primes
    send_bit(1'b0, 1'b1);
    wait_decision(4);
    for (int p = 0; p < 2; p++) begin
      for (int e = 0; e < 2; e++) begin
        for (int c = 0; c < 2; c++) begin
          send_bit(1'(p), 1'(p));  // sets the previous bit
          send_bit(1'(c), 1'(e));
          wait_decision(4);
        end
      end
    end
    send_idle();

    // random and one sided runs under default gains (freq and phase wrap)
    random_run(3000, 20);
    repeat (1200) send_kind(cdr_pkg::PD_LATE);
    repeat (1200) send_kind(cdr_pkg::PD_EARLY);
    random_run(1000, 10);

    // new gains mid run
    write_reg(cdr_pkg::REG_PHUG, 16'd1234);
    random_run(200, 10);
    write_reg(cdr_pkg::REG_FRUG, 16'd300);
    random_run(2000, 15);
    expect_read(cdr_pkg::REG_PHUG, 16'd1234);
    expect_read(cdr_pkg::REG_FRUG, 16'd300);

    // enable low freezes the code
    rd_addr = cdr_pkg::REG_CTRL;
    write_reg(cdr_pkg::REG_CTRL, 16'h0000);
    send_idle();
    @(posedge clk);
    #1;
    hold_code = m_phase >> (cdr_pkg::PHASE_W - cdr_pkg::CODE_W);  // frozen model code
    repeat (200) send_kind(($urandom_range(1) == 1) ? cdr_pkg::PD_LATE : cdr_pkg::PD_EARLY);
    send_idle();
    @(posedge clk);
    #1;
    assert (code === hold_code[cdr_pkg::CODE_W-1:0])
      else report_mismatch("code", hold_code, code);
    write_reg(cdr_pkg::REG_CTRL, 16'h0001);
    random_run(500, 10);

    // invalid counter saturation and clear by write
    rd_addr = cdr_pkg::REG_STATUS;
    write_reg(cdr_pkg::REG_STATUS, 16'h0000);
    repeat (300) send_kind(cdr_pkg::PD_INVALID);
    send_idle();
    expect_read(cdr_pkg::REG_STATUS, 16'd255);
    write_reg(cdr_pkg::REG_STATUS, 16'h005a);
    expect_read(cdr_pkg::REG_STATUS, 16'd0);

    // clear with a late decision landing on the same edge
    repeat (100) send_kind(cdr_pkg::PD_LATE);
    d = ~last_data;
    drive_cycle(1'b1, d, d, 1'b1, cdr_pkg::REG_CTRL, 16'h0003);
    last_data = d;
    send_kind(cdr_pkg::PD_LATE);
    @(posedge clk);
    #1;
    assert (code === '0) else report_mismatch("code", 0, code);
    repeat (50) send_kind(cdr_pkg::PD_LATE);
    random_run(500, 10);
    repeat (4) send_idle();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/cdr_sva.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on cdr_core, attached by bind below
module cdr_sva (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  sample_valid,
  input  cdr_pkg::pd_dec_t           pd_dec,
  input  cdr_pkg::loop_cfg_t         loop_cfg,
  input  wire logic [cdr_pkg::CODE_W-1:0] code
);

  int unsigned fail_cnt = 0;  // failures seen, read from the top

  logic upd;  // filter takes a decision at this edge

  assign upd = loop_cfg.enable && pd_dec.valid &&
               (pd_dec.dec == cdr_pkg::PD_EARLY || pd_dec.dec == cdr_pkg::PD_LATE);

  // no decision without a consumed sample
  a_valid_needs_sample: assert property (
    @(posedge clk) disable iff (!rst_n) !sample_valid |=> !pd_dec.valid
  ) else begin
    $error("pd_dec.valid high after a cycle without sample_valid");
    fail_cnt++;
  end

  // code only moves on an update or a clear
  a_code_stable: assert property (
    @(posedge clk) disable iff (!rst_n) (!upd && !loop_cfg.clear) |=> $stable(code)
  ) else begin
    $error("code changed without update or clear");
    fail_cnt++;
  end

  a_clear_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) loop_cfg.clear |=> !loop_cfg.clear
  ) else begin
    $error("clear high for two cycles");
    fail_cnt++;
  end

  // first edge out of reset
  a_code_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> (code == '0)
  ) else begin
    $error("code not zero after reset release");
    fail_cnt++;
  end

endmodule

bind cdr_core cdr_sva u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .sample_valid (sample_valid),
  .pd_dec       (pd_dec),
  .loop_cfg     (loop_cfg),
  .code         (code)
);

`default_nettype wire

//--- rtl/cdr_core.sv
`timescale 1ns/1ps
`default_nettype none

// cdr digital back end
// detector -> loop filter -> phase code, register block on the side
module cdr_core (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // sampler side
  input  wire logic                       sample_valid,
  input  wire logic                       data_smp,
  input  wire logic                       edge_smp,
  // register port
  input  wire logic                       cfg_we,
  input  cdr_pkg::cfg_addr_e              cfg_addr,
  input  wire logic [cdr_pkg::CFG_DW-1:0] cfg_wdata,
  output logic [cdr_pkg::CFG_DW-1:0]      cfg_rdata,
  // results
  output cdr_pkg::pd_dec_t                pd_dec,
  output logic [cdr_pkg::CODE_W-1:0]      code
);

  cdr_pkg::loop_cfg_t loop_cfg;  // gains, enable, clear pulse

  // one decision per valid sample, registered
  alexander_pd u_pd (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .data_smp     (data_smp),
    .edge_smp     (edge_smp),
    .pd_dec       (pd_dec)
  );

  // integrates decisions one edge later
  cdr_loop_filter u_filter (
    .clk      (clk),
    .rst_n    (rst_n),
    .pd_dec   (pd_dec),
    .loop_cfg (loop_cfg),
    .code     (code)
  );

  // counts invalid decisions too
  cdr_cfg_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .pd_dec    (pd_dec),
    .cfg_rdata (cfg_rdata),
    .loop_cfg  (loop_cfg)
  );

endmodule

`default_nettype wire

//--- rtl/cdr_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

// gain / control registers beside the loop filter
// write strobe, combinational read, no wait states
module cdr_cfg_regs (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      cfg_we,
  input  cdr_pkg::cfg_addr_e             cfg_addr,
  input  wire logic [cdr_pkg::CFG_DW-1:0] cfg_wdata,
  input  cdr_pkg::pd_dec_t               pd_dec,
  output logic [cdr_pkg::CFG_DW-1:0]     cfg_rdata,
  output cdr_pkg::loop_cfg_t             loop_cfg
);

  logic [cdr_pkg::PHUG_W-1:0] phug_q;
  logic [cdr_pkg::FRUG_W-1:0] frug_q;
  logic                       enable_q;
  logic                       clear_q;   // pulse, one cycle
  logic [cdr_pkg::CNT_W-1:0]  inv_cnt_q;  // invalid decisions seen

  logic                       wr_ctrl;
  logic                       wr_status;
  logic                       inv_hit;

  assign wr_ctrl   = cfg_we && (cfg_addr == cdr_pkg::REG_CTRL);
  assign wr_status = cfg_we && (cfg_addr == cdr_pkg::REG_STATUS);
  assign inv_hit   = pd_dec.valid && (pd_dec.dec == cdr_pkg::PD_INVALID);

  // gains and enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phug_q   <= cdr_pkg::PHUG_RST;
      frug_q   <= cdr_pkg::FRUG_RST;
      enable_q <= 1'b1;  // loop runs out of reset
    end else if (cfg_we) begin
      case (cfg_addr)
        cdr_pkg::REG_PHUG: phug_q <= cfg_wdata[cdr_pkg::PHUG_W-1:0];
        cdr_pkg::REG_FRUG: frug_q <= cfg_wdata[cdr_pkg::FRUG_W-1:0];
        cdr_pkg::REG_CTRL: enable_q <= cfg_wdata[cdr_pkg::CTRL_EN_BIT];
        default: ;  // status handled by the counter
      endcase
    end
  end

  // clear strobe, drops by itself next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= wr_ctrl && cfg_wdata[cdr_pkg::CTRL_CLR_BIT];
    end
  end

  // saturating invalid counter, any status write zeroes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inv_cnt_q <= '0;
    end else if (wr_status) begin
      inv_cnt_q <= '0;
    end else if (inv_hit && (inv_cnt_q != cdr_pkg::CNT_MAX)) begin
      inv_cnt_q <= inv_cnt_q + 1'b1;
    end
  end

  // read mux, unused bits zero
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      cdr_pkg::REG_PHUG:   cfg_rdata[cdr_pkg::PHUG_W-1:0] = phug_q;
      cdr_pkg::REG_FRUG:   cfg_rdata[cdr_pkg::FRUG_W-1:0] = frug_q;
      cdr_pkg::REG_CTRL:   cfg_rdata[cdr_pkg::CTRL_EN_BIT] = enable_q;  // clear reads 0
      cdr_pkg::REG_STATUS: cfg_rdata[cdr_pkg::CNT_W-1:0] = inv_cnt_q;
      default:             cfg_rdata = '0;
    endcase
  end

  assign loop_cfg.phug   = phug_q;
  assign loop_cfg.frug   = frug_q;
  assign loop_cfg.enable = enable_q;
  assign loop_cfg.clear  = clear_q;

endmodule

`default_nettype wire

//--- rtl/cdr_loop_filter.sv
`timescale 1ns/1ps
`default_nettype none

// second order bang-bang loop filter
// freq integrator accumulates +-frug, phase integrator takes freq slice plus +-phug
module cdr_loop_filter (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  cdr_pkg::pd_dec_t              pd_dec,
  input  cdr_pkg::loop_cfg_t            loop_cfg,
  output logic [cdr_pkg::CODE_W-1:0]    code
);

  localparam int PH_W = cdr_pkg::PHASE_W;
  localparam int FR_W = cdr_pkg::FREQ_W;

  logic [FR_W-1:0]        freq_q;   // two's complement
  logic [PH_W-1:0]        phase_q;
  logic [FR_W-1:0]        freq_d;
  logic [PH_W-1:0]        phase_d;

  logic signed [FR_W-1:0] freq_shr;   // freq >>> FREQ_SHIFT
  logic [PH_W-1:0]        freq_term;  // sign extended to phase width
  logic [PH_W-1:0]        phug_ext;
  logic [FR_W-1:0]        frug_ext;

  logic                   is_late;
  logic                   is_early;
  logic                   update;

  // only real transitions move the loop
  assign is_late  = pd_dec.valid && (pd_dec.dec == cdr_pkg::PD_LATE);
  assign is_early = pd_dec.valid && (pd_dec.dec == cdr_pkg::PD_EARLY);
  assign update   = loop_cfg.enable && (is_late || is_early);

  // signed slice of the frequency word, works in both directions
  assign freq_shr  = $signed(freq_q) >>> cdr_pkg::FREQ_SHIFT;
  assign freq_term = {{(PH_W-FR_W){freq_shr[FR_W-1]}}, freq_shr};

  // gains are unsigned magnitudes
  assign phug_ext = {{(PH_W-cdr_pkg::PHUG_W){1'b0}}, loop_cfg.phug};
  assign frug_ext = {{(FR_W-cdr_pkg::FRUG_W){1'b0}}, loop_cfg.frug};

  always_comb begin
    freq_d  = freq_q;
    phase_d = phase_q;
    if (update) begin
      // phase uses the old freq value, both wrap naturally
      if (is_late) begin
        freq_d  = freq_q + frug_ext;
        phase_d = phase_q + freq_term + phug_ext;
      end else begin
        freq_d  = freq_q - frug_ext;
        phase_d = phase_q + freq_term - phug_ext;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      freq_q  <= '0;
      phase_q <= '0;
    end else if (loop_cfg.clear) begin
      // clear wins over any decision in the same cycle
      freq_q  <= '0;
      phase_q <= '0;
    end else begin
      freq_q  <= freq_d;
      phase_q <= phase_d;
    end
  end

  // top bits drive the oscillator / interpolator
  assign code = phase_q[PH_W-1 -: cdr_pkg::CODE_W];

endmodule

`default_nettype wire

//--- rtl/alexander_pd.sv
`timescale 1ns/1ps
`default_nettype none

// alexander (bang-bang) phase detector
// compares previous data bit, edge sample between bits and current data bit
module alexander_pd (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             sample_valid,  // one pair per recovered bit
  input  wire logic             data_smp,
  input  wire logic             edge_smp,
  output cdr_pkg::pd_dec_t      pd_dec
);

  logic              prev_q;   // last data sample
  logic              primed_q;  // prev_q holds a real sample
  cdr_pkg::pd_dec_e  dec_c;     // classification of the incoming pair
  cdr_pkg::pd_dec_t  pd_dec_q;

  // truth table over prev / edge / current
  always_comb begin
    if (prev_q == data_smp) begin
      // no data transition, edge should agree
      if (edge_smp == data_smp) begin
        dec_c = cdr_pkg::PD_NONE;
      end else begin
        dec_c = cdr_pkg::PD_INVALID;  // glitch or sampler error
      end
    end else begin
      // transition, edge tells which side the clock sits
      if (edge_smp == prev_q) begin
        dec_c = cdr_pkg::PD_EARLY;
      end else begin
        dec_c = cdr_pkg::PD_LATE;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_q   <= 1'b0;
      primed_q <= 1'b0;
      pd_dec_q <= '0;  // valid low, PD_NONE
    end else begin
      pd_dec_q.valid <= sample_valid;  // pulse only for consumed pairs
      if (sample_valid) begin
        prev_q   <= data_smp;
        primed_q <= 1'b1;
        // first sample after reset has no history to compare
        if (primed_q) begin
          pd_dec_q.dec <= dec_c;
        end else begin
          pd_dec_q.dec <= cdr_pkg::PD_NONE;
        end
      end
    end
  end

  assign pd_dec = pd_dec_q;

endmodule

`default_nettype wire

//--- rtl/cdr_pkg.sv
`default_nettype none

package cdr_pkg;

  // accumulator widths
  localparam int PHASE_W = 24;  // phase integrator, wraps mod 2^24
  localparam int FREQ_W = 16;  // signed frequency integrator
  localparam int CODE_W = 11;  // fixed by the oscillator interface

  // frequency term seen by the phase integrator is freq >>> FREQ_SHIFT
  localparam int FREQ_SHIFT = 7;

  // proportional gain
  localparam int PHUG_W = 12;
  localparam logic [PHUG_W-1:0] PHUG_RST = 12'd500;

  // integral gain
  localparam int FRUG_W = 10;
  localparam logic [FRUG_W-1:0] FRUG_RST = 10'd80;

  // invalid pattern counter, saturating
  localparam int CNT_W = 8;
  localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

  // register data path
  localparam int CFG_DW = 16;

  // bit positions inside CTRL
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_CLR_BIT = 1;  // write only, reads back as zero

  // phase detector outcome per bit
  typedef enum logic [1:0] {
    PD_NONE    = 2'd0,  // no transition
    PD_EARLY   = 2'd1,  // edge matches previous bit
    PD_LATE    = 2'd2,  // edge matches current bit
    PD_INVALID = 2'd3   // edge differs from two equal bits
  } pd_dec_e;

  // decision as it leaves the detector
  typedef struct packed {
    logic    valid;  // one pulse per consumed sample
    pd_dec_e dec;
  } pd_dec_t;

  // register map, word addressed
  typedef enum logic [1:0] {
    REG_PHUG   = 2'd0,
    REG_FRUG   = 2'd1,
    REG_CTRL   = 2'd2,
    REG_STATUS = 2'd3
  } cfg_addr_e;

  // filter configuration from the register block
  typedef struct packed {
    logic [PHUG_W-1:0] phug;
    logic [FRUG_W-1:0] frug;
    logic              enable;  // filter ignores decisions when low
    logic              clear;   // single cycle pulse
  } loop_cfg_t;

endpackage

`default_nettype wire
